//--- Bender.yml
package:
  name: io_board

sources:
  - files:
      - hw/io_board_pkg.sv
      - hw/event_latch.sv
      - hw/tick_timer.sv
      - hw/xbus_io.sv
      - hw/io_board.sv
  - target: test
    files:
      - verification/io_board_props.sv
      - verification/io_board_tb.sv

//--- hw/event_latch.sv
// Device sample register with an unread flag, generic over the payload type.
`timescale 1ns/1ps
`default_nettype none

module event_latch
#(
   parameter type payload_t = logic [31:0]
)
(
   input  logic     clk,
   input  logic     reset,
   input  logic     capture,
   input  payload_t data_in,
   input  logic     clear,
   output payload_t data_out,
   output logic     ready
);

   // Sample register.
   always_ff @(posedge clk)
   begin
      if (capture)
         data_out <= data_in;
   end

   // A sample arriving during a read must not be lost, so capture wins.
   always_ff @(posedge clk)
   begin
      if (reset)
         ready <= 1'b0;
      else if (capture)
         ready <= 1'b1;
      else if (clear)
         ready <= 1'b0;
   end

endmodule

`default_nettype wire

//--- hw/io_board.sv
// I/O board top level: Xbus slave, keyboard and mouse latches, microsecond and 60 Hz timers.
`timescale 1ns/1ps
`default_nettype none

module io_board
#(
   parameter int unsigned SYS_CLK_HZ   = 50000000,
   parameter int unsigned US_RATE_HZ   = 1000000,
   parameter int unsigned HZ60_RATE_HZ = 60
)
(
   input  logic                       clk,
   input  logic                       reset,
   input  logic                       req,
   input  logic                       write,
   input  io_board_pkg::addr_t        addr,
   input  io_board_pkg::data_t        datain,
   output io_board_pkg::data_t        dataout,
   output logic                       ack,
   output logic                       decode,
   output logic                       interrupt,
   input  logic                       key_strobe,
   input  io_board_pkg::key_scan_t    key_scan,
   input  logic                       mouse_strobe,
   input  io_board_pkg::mouse_state_t mouse_in
);

   localparam int unsigned US_DIV   = SYS_CLK_HZ / US_RATE_HZ;
   localparam int unsigned HZ60_DIV = SYS_CLK_HZ / HZ60_RATE_HZ;

   io_board_pkg::key_scan_t    kbd_data;
   io_board_pkg::mouse_state_t mouse_data;
   logic                       kbd_ready, kbd_clear;
   logic                       mouse_ready, mouse_clear;
   io_board_pkg::data_t        usec_count, hz60_count;
   logic                       hz60_tick;

   xbus_io xbus_io_inst
   (
      .clk, .reset, .req, .write, .addr, .datain, .dataout, .ack, .decode, .interrupt,
      .kbd_data, .kbd_ready, .kbd_clear,
      .mouse_data, .mouse_ready, .mouse_clear,
      .usec_count, .hz60_count, .hz60_tick
   );

   event_latch #(.payload_t(io_board_pkg::key_scan_t)) kbd_latch_inst
   (
      .clk, .reset, .capture(key_strobe), .data_in(key_scan), .clear(kbd_clear),
      .data_out(kbd_data), .ready(kbd_ready)
   );

   event_latch #(.payload_t(io_board_pkg::mouse_state_t)) mouse_latch_inst
   (
      .clk, .reset, .capture(mouse_strobe), .data_in(mouse_in), .clear(mouse_clear),
      .data_out(mouse_data), .ready(mouse_ready)
   );

   tick_timer #(.DIV(US_DIV)) usec_timer_inst
   (
      .clk, .reset, .count(usec_count), .tick()
   );

   tick_timer #(.DIV(HZ60_DIV)) hz60_timer_inst
   (
      .clk, .reset, .count(hz60_count), .tick(hz60_tick)
   );

endmodule

`default_nettype wire

//--- hw/io_board_pkg.sv
// Shared Xbus widths, I/O board register map, ready bit indexes and device word types.
`default_nettype none

package io_board_pkg;

   typedef logic [21:0] addr_t;   // Xbus word address.
   typedef logic [31:0] data_t;   // Xbus data word.

   // Board window, 64 words from here.
   localparam addr_t IO_BASE = 22'o17772000;

   localparam addr_t KBD_LO_ADDR  = 22'o17772040;
   localparam addr_t KBD_HI_ADDR  = 22'o17772041;
   localparam addr_t MOUSE_Y_ADDR = 22'o17772042;
   localparam addr_t MOUSE_X_ADDR = 22'o17772043;
   localparam addr_t BEEP_ADDR    = 22'o17772044;   // Acks, reads zero.
   localparam addr_t KBD_CSR_ADDR = 22'o17772045;
   localparam addr_t USEC_LO_ADDR = 22'o17772050;
   localparam addr_t USEC_HI_ADDR = 22'o17772051;
   localparam addr_t HZ60_ADDR    = 22'o17772052;   // Read arms 60 Hz ready.

   // Index into the enable bits and into the ready bits.
   localparam int unsigned RDY_MOUSE = 0;
   localparam int unsigned RDY_KBD   = 1;
   localparam int unsigned RDY_CLK   = 2;
   localparam int unsigned RDY_W     = 3;

   // Mouse sample as delivered by the mouse decoder.
   typedef struct packed
   {
      logic        head;
      logic        middle;
      logic        tail;
      logic [11:0] y;
      logic [11:0] x;
      logic [1:0]  rawy;
      logic [1:0]  rawx;
   } mouse_state_t;

   typedef logic [31:0] key_scan_t;   // Keyboard scan word.

endpackage

`default_nettype wire

//--- hw/tick_timer.sv
// Clock prescaler with a one-cycle tick and a 32-bit running tick count.
`timescale 1ns/1ps
`default_nettype none

module tick_timer
#(
   parameter int unsigned DIV = 12
)
(
   input  logic                clk,
   input  logic                reset,
   output io_board_pkg::data_t count,
   output logic                tick
);

   localparam int unsigned PW = (DIV > 1) ? $clog2(DIV) : 1;
   localparam logic [PW-1:0] LAST = PW'(DIV - 1);

   logic [PW-1:0] prescale;
   logic          wrap;

   assign wrap = (prescale == LAST);

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         prescale <= '0;
         count    <= '0;
         tick     <= 1'b0;
      end
      else
      begin
         tick <= wrap;                  // One pulse per period.
         if (wrap)
         begin
            prescale <= '0;
            count    <= count + 32'd1;
         end
         else
            prescale <= prescale + 1'b1;
      end
   end

endmodule

`default_nettype wire

//--- hw/xbus_io.sv
// Xbus slave for the I/O board: decode, delayed ack, read mux, CSR, 60 Hz arm, interrupt.
`timescale 1ns/1ps
`default_nettype none

module xbus_io
(
   input  logic                       clk,
   input  logic                       reset,
   input  logic                       req,
   input  logic                       write,
   input  io_board_pkg::addr_t        addr,
   input  io_board_pkg::data_t        datain,
   output io_board_pkg::data_t        dataout,
   output logic                       ack,
   output logic                       decode,
   output logic                       interrupt,
   input  io_board_pkg::key_scan_t    kbd_data,
   input  logic                       kbd_ready,
   output logic                       kbd_clear,
   input  io_board_pkg::mouse_state_t mouse_data,
   input  logic                       mouse_ready,
   output logic                       mouse_clear,
   input  io_board_pkg::data_t        usec_count,
   input  io_board_pkg::data_t        hz60_count,
   input  logic                       hz60_tick
);

   logic [1:0]                     ack_delay;
   logic                           bus_start;   // First cycle of a bus cycle.
   logic                           rd;
   logic [3:0]                     csr;
   logic                           hz60_armed;
   logic                           clk_ready;
   logic [io_board_pkg::RDY_W-1:0] rdy_vec;
   io_board_pkg::data_t            read_data;

   // Upper sixteen address bits select the board.
   assign decode    = req & ({addr[21:6], 6'b0} == io_board_pkg::IO_BASE);
   assign ack       = ack_delay[1];
   assign bus_start = decode & ~ack_delay[0];
   assign rd        = decode & ~write;

   always_comb
   begin
      rdy_vec                          = '0;
      rdy_vec[io_board_pkg::RDY_MOUSE] = mouse_ready;
      rdy_vec[io_board_pkg::RDY_KBD]   = kbd_ready;
      rdy_vec[io_board_pkg::RDY_CLK]   = clk_ready;
   end

   // Register read mux.
   always_comb
   begin
      case (addr)
         io_board_pkg::KBD_LO_ADDR:  read_data = {16'b0, kbd_data[15:0]};
         io_board_pkg::KBD_HI_ADDR:  read_data = {16'b0, kbd_data[31:16]};
         io_board_pkg::MOUSE_Y_ADDR:
            read_data = {17'b0, mouse_data.head, mouse_data.middle,
                         mouse_data.tail, mouse_data.y};
         io_board_pkg::MOUSE_X_ADDR:
            read_data = {16'b0, mouse_data.rawy, mouse_data.rawx, mouse_data.x};
         io_board_pkg::BEEP_ADDR:    read_data = '0;
         io_board_pkg::KBD_CSR_ADDR: read_data = {25'b0, rdy_vec, csr};
         io_board_pkg::USEC_LO_ADDR: read_data = {16'b0, usec_count[15:0]};
         io_board_pkg::USEC_HI_ADDR: read_data = {16'b0, usec_count[31:16]};
         io_board_pkg::HZ60_ADDR:    read_data = hz60_count;
         default:                    read_data = '0;   // Unmapped in window.
      endcase
   end

   // Ack trails decode by two edges.
   always_ff @(posedge clk)
   begin
      if (reset)
         ack_delay <= 2'b00;
      else
         ack_delay <= {ack_delay[0], decode};
   end

   always_ff @(posedge clk)
   begin
      if (reset)
         dataout <= '0;
      else if (decode)
         dataout <= read_data;   // Held once req drops.
   end

   // CSR write and 60 Hz arming repeat while req is held.
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         csr        <= 4'b0;
         hz60_armed <= 1'b0;
         clk_ready  <= 1'b0;
      end
      else
      begin
         if (decode && write && addr == io_board_pkg::KBD_CSR_ADDR)
            csr <= datain[3:0];
         if (rd && addr == io_board_pkg::HZ60_ADDR)
            hz60_armed <= 1'b1;
         if (hz60_tick && hz60_armed)
            clk_ready <= 1'b1;
         else if (bus_start && rd && addr == io_board_pkg::HZ60_ADDR)
            clk_ready <= 1'b0;
      end
   end

   // Ready clears fire once per bus cycle.
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         kbd_clear   <= 1'b0;
         mouse_clear <= 1'b0;
      end
      else
      begin
         kbd_clear   <= bus_start & rd & (addr == io_board_pkg::KBD_LO_ADDR ||
                                          addr == io_board_pkg::KBD_HI_ADDR);
         mouse_clear <= bus_start & rd & (addr == io_board_pkg::MOUSE_Y_ADDR);
      end
   end

   always_ff @(posedge clk)
   begin
      if (reset)
         interrupt <= 1'b0;
      else
         interrupt <= |(rdy_vec & csr[io_board_pkg::RDY_W-1:0]);
   end

endmodule

`default_nettype wire

//--- io_board.f
hw/io_board_pkg.sv
hw/event_latch.sv
hw/tick_timer.sv
hw/xbus_io.sv
hw/io_board.sv
verification/io_board_props.sv
verification/io_board_tb.sv

//--- verification/io_board_props.sv
// Concurrent bus and interrupt properties for the Xbus slave, bound into xbus_io.
`timescale 1ns/1ps
`default_nettype none

module io_board_props
(
   input logic       clk,
   input logic       reset,
   input logic       req,
   input logic       decode,
   input logic       ack,
   input logic       interrupt,
   input logic       mouse_ready,
   input logic       kbd_ready,
   input logic       clk_ready,
   input logic [3:0] csr
);

   // Two-stage ack delay.
   ack_follows_decode: assert property (@(posedge clk) disable iff (reset)
      ack |-> $past(decode, 2))
      else $error("ack without decode two cycles earlier");

   decode_needs_req: assert property (@(posedge clk) disable iff (reset)
      decode |-> req)
      else $error("decode high while req is low");

   // Registered interrupt source, each flag paired with its own enable.
   interrupt_has_source: assert property (@(posedge clk) disable iff (reset)
      interrupt |-> $past((mouse_ready && csr[io_board_pkg::RDY_MOUSE]) ||
                          (kbd_ready && csr[io_board_pkg::RDY_KBD]) ||
                          (clk_ready && csr[io_board_pkg::RDY_CLK])))
      else $error("interrupt without a ready bit and its enable");

endmodule

bind xbus_io io_board_props props_inst
(
   .clk(clk), .reset(reset), .req(req), .decode(decode), .ack(ack),
   .interrupt(interrupt), .mouse_ready(mouse_ready), .kbd_ready(kbd_ready),
   .clk_ready(clk_ready), .csr(csr)
);

`default_nettype wire

//--- verification/io_board_tb.sv
// Testbench for the I/O board: clock, reset, device strobes, bus cycle table and timer checks.
`timescale 1ns/1ps
`default_nettype none

module io_board_tb;

   localparam int TIMEOUT = 50;   // Cycles per wait.
   localparam io_board_pkg::data_t MOUSE_RDY = 32'd1 << (4 + io_board_pkg::RDY_MOUSE);
   localparam io_board_pkg::data_t KBD_RDY   = 32'd1 << (4 + io_board_pkg::RDY_KBD);
   localparam io_board_pkg::data_t CLK_RDY   = 32'd1 << (4 + io_board_pkg::RDY_CLK);
   localparam io_board_pkg::addr_t UNMAPPED_ADDR = io_board_pkg::IO_BASE + 22'o13;
   localparam io_board_pkg::addr_t OUTSIDE_ADDR  = io_board_pkg::IO_BASE - 22'o100;

   typedef struct packed
   {
      logic                wr;
      io_board_pkg::addr_t addr;
      io_board_pkg::data_t wdata;
      io_board_pkg::data_t exp_data;
      io_board_pkg::data_t mask;
   } bus_op_t;

   logic                       clk, reset, req, write, ack, decode, interrupt;
   logic                       key_strobe, mouse_strobe;
   io_board_pkg::addr_t        addr;
   io_board_pkg::data_t        datain, dataout;
   io_board_pkg::key_scan_t    key_scan, scan_a, scan_b;
   io_board_pkg::mouse_state_t mouse_in, mouse_a;
   bus_op_t                    ops [0:15];
   int unsigned                cycles;

   io_board #(.SYS_CLK_HZ(1200), .US_RATE_HZ(100), .HZ60_RATE_HZ(60)) io_board_inst
   (
      .clk, .reset, .req, .write, .addr, .datain, .dataout, .ack, .decode, .interrupt,
      .key_strobe, .key_scan, .mouse_strobe, .mouse_in
   );

   initial
   begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   always @(posedge clk)
      cycles <= cycles + 1;   // Reference for timer checks.

   task automatic report_mismatch(input string what, input io_board_pkg::data_t got,
                                  input io_board_pkg::data_t exp);
      $display("mismatch at time %0t: %s, got %h, expected %h", $time, what, got, exp);
      $display("tests failed");
      $fatal(1, "stopped at the first error");
   endtask

   task automatic report_failure(input string what);
      $display("error at time %0t: %s", $time, what);
      $display("tests failed");
      $fatal(1, "stopped at the first error");
   endtask

   task automatic check_value(input string what, input io_board_pkg::data_t got,
                              input io_board_pkg::data_t exp, input io_board_pkg::data_t mask);
      assert ((got & mask) == (exp & mask))
      else report_mismatch(what, got & mask, exp & mask);
   endtask

   // One Xbus cycle, called on a falling edge.
   task automatic bus_cycle(input logic wr, input io_board_pkg::addr_t a,
                            input io_board_pkg::data_t wd, output io_board_pkg::data_t rd);
      int n;
      req    = 1'b1;
      write  = wr;
      addr   = a;
      datain = wd;
      n      = 0;
      do
      begin
         @(negedge clk);
         n++;
      end
      while (!ack && n < TIMEOUT);
      assert (ack) else report_failure("timed out waiting for ack to rise");
      rd    = dataout;
      req   = 1'b0;
      write = 1'b0;
      n     = 0;
      while (ack && n < TIMEOUT)
      begin
         @(negedge clk);
         n++;
      end
      assert (!ack) else report_failure("timed out waiting for ack to fall");
   endtask

   task automatic apply_ops(input int first, input int last);
      io_board_pkg::data_t got;
      for (int i = first; i <= last; i++)
      begin
         bus_cycle(ops[i].wr, ops[i].addr, ops[i].wdata, got);
         if (!ops[i].wr)
            check_value($sformatf("table entry %0d", i), got, ops[i].exp_data, ops[i].mask);
      end
   endtask

   task automatic wait_interrupt(input logic level, input string what);
      int n;
      n = 0;
      while (interrupt !== level && n < TIMEOUT)
      begin
         @(negedge clk);
         n++;
      end
      assert (interrupt === level) else report_failure(what);
   endtask

   task automatic strobe_key(input io_board_pkg::key_scan_t scan);
      key_scan   = scan;
      key_strobe = 1'b1;
      @(negedge clk);
      key_strobe = 1'b0;
   endtask

   function automatic bus_op_t make_op(input logic wr, input io_board_pkg::addr_t a,
                                       input io_board_pkg::data_t wd,
                                       input io_board_pkg::data_t exp,
                                       input io_board_pkg::data_t mask);
      make_op = '{wr: wr, addr: a, wdata: wd, exp_data: exp, mask: mask};
   endfunction

   task automatic fill_table();
      ops[0]  = make_op(0, io_board_pkg::KBD_CSR_ADDR, 0, KBD_RDY, KBD_RDY);
      ops[1]  = make_op(0, io_board_pkg::KBD_LO_ADDR, 0, {16'b0, scan_a[15:0]}, '1);
      ops[2]  = make_op(0, io_board_pkg::KBD_HI_ADDR, 0, {16'b0, scan_a[31:16]}, '1);
      ops[3]  = make_op(0, io_board_pkg::KBD_CSR_ADDR, 0, 0, KBD_RDY);
      ops[4]  = make_op(0, io_board_pkg::KBD_CSR_ADDR, 0, MOUSE_RDY, MOUSE_RDY);
      ops[5]  = make_op(0, io_board_pkg::MOUSE_X_ADDR, 0,
                        {16'b0, mouse_a.rawy, mouse_a.rawx, mouse_a.x}, '1);
      ops[6]  = make_op(0, io_board_pkg::KBD_CSR_ADDR, 0, MOUSE_RDY, MOUSE_RDY);
      ops[7]  = make_op(0, io_board_pkg::MOUSE_Y_ADDR, 0,
                        {17'b0, mouse_a.head, mouse_a.middle, mouse_a.tail, mouse_a.y}, '1);
      ops[8]  = make_op(0, io_board_pkg::KBD_CSR_ADDR, 0, 0, MOUSE_RDY);
      ops[9]  = make_op(1, io_board_pkg::KBD_CSR_ADDR, 32'hA, 0, 0);
      ops[10] = make_op(0, io_board_pkg::KBD_CSR_ADDR, 0, 32'hA, 32'hF);
      ops[11] = make_op(1, io_board_pkg::KBD_CSR_ADDR, 0, 0, 0);
      ops[12] = make_op(1, io_board_pkg::KBD_CSR_ADDR, 32'd1 << io_board_pkg::RDY_KBD, 0, 0);
      ops[13] = make_op(0, io_board_pkg::KBD_LO_ADDR, 0, {16'b0, scan_b[15:0]}, '1);
      ops[14] = make_op(0, io_board_pkg::BEEP_ADDR, 0, 0, '1);
      ops[15] = make_op(0, UNMAPPED_ADDR, 0, 0, '1);
   endtask

   initial
   begin
      io_board_pkg::data_t got, first_val, last_val, diff;
      int unsigned         c_first, n;
      logic [30:0]         mouse_bits;
      reset = 1'b1;
      req = 1'b0;
      write = 1'b0;
      addr = '0;
      datain = '0;
      key_strobe = 1'b0;
      key_scan = '0;
      mouse_strobe = 1'b0;
      mouse_in = '0;
      cycles = 0;
      void'($urandom(32'h53c4));
      scan_a     = $urandom;
      scan_b     = $urandom;
      mouse_bits = 31'($urandom);
      mouse_a    = mouse_bits;
      fill_table();
      repeat (5) @(negedge clk);
      reset = 1'b0;
      @(negedge clk);

      strobe_key(scan_a);   // Keyboard path.
      apply_ops(0, 3);
      mouse_in     = mouse_a;
      mouse_strobe = 1'b1;
      @(negedge clk);
      mouse_strobe = 1'b0;
      apply_ops(4, 11);

      // Keyboard interrupt with the enable clear, then set.
      strobe_key(scan_b);
      repeat (10)
      begin
         @(negedge clk);
         assert (!interrupt) else report_failure("interrupt high with its enable clear");
      end
      apply_ops(12, 12);
      wait_interrupt(1'b1, "timed out waiting for interrupt to rise");
      apply_ops(13, 13);
      wait_interrupt(1'b0, "timed out waiting for interrupt to fall");
      apply_ops(14, 15);

      // Microsecond clock over a random gap.
      bus_cycle(0, io_board_pkg::USEC_LO_ADDR, 0, first_val);
      c_first = cycles;
      repeat ($urandom_range(40, 80)) @(negedge clk);
      bus_cycle(0, io_board_pkg::USEC_LO_ADDR, 0, last_val);
      n    = cycles - c_first;
      diff = (last_val - first_val) & 32'hFFFF;
      assert (diff >= n / 12 && diff <= n / 12 + 1)
      else report_mismatch("microsecond count step", diff, n / 12);

      // 60 Hz ready flag stays clear until armed.
      bus_cycle(0, io_board_pkg::KBD_CSR_ADDR, 0, got);
      check_value("clock ready before arming", got, 0, CLK_RDY);
      repeat (25) @(negedge clk);
      bus_cycle(0, io_board_pkg::KBD_CSR_ADDR, 0, got);
      check_value("clock ready before arming", got, 0, CLK_RDY);
      bus_cycle(0, io_board_pkg::HZ60_ADDR, 0, first_val);
      c_first = cycles;
      repeat (21) @(negedge clk);
      bus_cycle(0, io_board_pkg::KBD_CSR_ADDR, 0, got);
      check_value("clock ready after arming", got, CLK_RDY, CLK_RDY);
      repeat (70) @(negedge clk);
      bus_cycle(0, io_board_pkg::HZ60_ADDR, 0, last_val);
      n    = cycles - c_first;
      diff = last_val - first_val;
      assert (diff >= n / 20 && diff <= n / 20 + 1)
      else report_mismatch("60 Hz count step", diff, n / 20);

      // Outside the window, no decode and no ack.
      req  = 1'b1;
      addr = OUTSIDE_ADDR;
      repeat (TIMEOUT)
      begin
         @(negedge clk);
         assert (!decode && !ack) else report_failure("outside address was decoded");
      end
      req = 1'b0;
      @(negedge clk);

      $display("all tests passed");
      $finish;
   end

endmodule

`default_nettype wire
